// ==== hdl/creditCounter.sv ====
/*
  Push credit counter
  Releases the initial credits one per cycle after reset and returns
  one credit for every entry that goes back to the free list
*/
`timescale 1ns/1ps
`default_nettype none

module creditCounter
  import mfifoPkg::*;
(
  input  logic clk,
  input  logic rstN,
  input  logic freeValid,
  output logic pushCredit
);

  // Credits that the sender is still owed
  countT owed;
  logic issue;

  // A credit goes out when one is owed or an entry is freed right now,
  // so a freed entry shows up as a credit on the very next cycle
  assign issue = (owed != '0) || freeValid;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      owed <= countT'(Depth);
      pushCredit <= 1'b0;
    end else begin
      // Issue and free may coincide and then cancel out
      owed <= owed + countT'(freeValid) - countT'(issue);
      pushCredit <= issue;
    end
  end

  // Every free matches a credit handed out earlier, so the owed count
  // plus the credit it returns never exceeds the number of entries
  owedBound: assert property (@(posedge clk) disable iff (!rstN)
    owed + countT'(freeValid) <= countT'(Depth));

endmodule

`default_nettype wire

// ==== hdl/mfifoPkg.sv ====
/*
  Shared multi-FIFO sizes and types
  Four logical FIFOs share one 16-entry data RAM through linked lists
*/
`default_nettype none

package mfifoPkg;

  // Entries in the shared data RAM and in the pointer RAM
  localparam int Depth = 16;

  // Logical FIFOs that share the storage
  localparam int NumFifos = 4;

  // Payload bits per entry
  localparam int Width = 8;

  // Index widths derived from the sizes above
  localparam int AddrWidth = 4;
  localparam int FifoIdWidth = 2;

  // Counts run from zero up to Depth, so one extra bit is needed
  localparam int CountWidth = 5;

  // One payload word
  typedef logic [Width-1:0] dataT;

  // Entry index, also the content of a pointer RAM word
  typedef logic [AddrWidth-1:0] addrT;

  // Logical FIFO number
  typedef logic [FifoIdWidth-1:0] fifoIdT;

  // Item or credit count
  typedef logic [CountWidth-1:0] countT;

endpackage

`default_nettype wire

// ==== hdl/popCtrl.sv ====
/*
  Pop controller
  Refills the per-FIFO staging registers from the data RAM in round-robin
  order and serves each FIFO's valid/ready pop port
*/
`timescale 1ns/1ps
`default_nettype none

module popCtrl
  import mfifoPkg::*;
(
  input  logic                clk,
  input  logic                rstN,
  input  logic [NumFifos-1:0] listEmpty,
  input  logic [NumFifos-1:0] headValid,
  input  addrT [NumFifos-1:0] head,
  input  dataT                dataRdData,
  input  logic [NumFifos-1:0] popReady,
  output logic                consumeValid,
  output fifoIdT              consumeFifoId,
  output logic                freeValid,
  output addrT                freeEntry,
  output logic                dataRdEn,
  output addrT                dataRdAddr,
  output logic [NumFifos-1:0] popValid,
  output dataT [NumFifos-1:0] popData,
  output logic [NumFifos-1:0] popEmpty
);

  // Low is Idle, high is Fill
  logic inFill;
  fifoIdT fillFifo;
  fifoIdT rrPtr;
  logic [NumFifos-1:0] stageFull;
  dataT [NumFifos-1:0] stageData;
  logic [NumFifos-1:0] eligible;
  logic found;
  fifoIdT pick;

  // Room to stage, and a settled head to read
  assign eligible = ~stageFull & ~listEmpty & headValid;

  // Search starts at the round-robin pointer and wraps
  always_comb begin : rrPick
    fifoIdT idx;
    found = 1'b0;
    pick = rrPtr;
    for (int i = 0; i < NumFifos; i++) begin
      idx = rrPtr + fifoIdT'(i);
      if (!found && eligible[idx]) begin
        found = 1'b1;
        pick = idx;
      end
    end
  end

  // In Idle one pick reads the RAM, pops the list head and frees the entry
  assign consumeValid = !inFill && found;
  assign consumeFifoId = pick;
  assign freeValid = consumeValid;
  assign freeEntry = head[pick];
  assign dataRdEn = consumeValid;
  assign dataRdAddr = head[pick];

  assign popValid = stageFull;
  assign popData = stageData;

  always_comb begin
    for (int f = 0; f < NumFifos; f++) begin
      // An item on its way from the RAM keeps the FIFO from looking empty
      popEmpty[f] = listEmpty[f] && !stageFull[f] && !(inFill && (fillFifo == fifoIdT'(f)));
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      inFill <= 1'b0;
      fillFifo <= '0;
      rrPtr <= '0;
      stageFull <= '0;
    end else begin
      inFill <= consumeValid;
      if (consumeValid) begin
        fillFifo <= pick;
        rrPtr <= pick + fifoIdT'(1);
      end
      stageFull <= stageFull & ~(popValid & popReady);
      if (inFill) begin
        stageFull[fillFifo] <= 1'b1;
      end
    end
  end

  // RAM data for the picked FIFO arrives during Fill
  always_ff @(posedge clk) begin
    if (inFill) begin
      stageData[fillFifo] <= dataRdData;
    end
  end

  // The pointer manager may only offer a head on a list that holds items
  headOnItem: assert property (@(posedge clk) disable iff (!rstN)
    (headValid & listEmpty) == '0);

endmodule

`default_nettype wire

// ==== hdl/ptrMgr.sv ====
/*
  Linked-list pointer manager
  Tracks head, tail and item count of every logical FIFO, writes links
  into the pointer RAM on append and follows them on consume
*/
`timescale 1ns/1ps
`default_nettype none

module ptrMgr
  import mfifoPkg::*;
(
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 appendValid,
  input  fifoIdT               appendFifoId,
  input  addrT                 appendEntry,
  input  logic                 consumeValid,
  input  fifoIdT               consumeFifoId,
  input  addrT                 ptrRdData,
  output logic [NumFifos-1:0]  listEmpty,
  output logic [NumFifos-1:0]  headValid,
  output addrT [NumFifos-1:0]  head,
  output logic                 ptrWrEn,
  output addrT                 ptrWrAddr,
  output addrT                 ptrWrData,
  output logic                 ptrRdEn,
  output addrT                 ptrRdAddr
);

  addrT [NumFifos-1:0] tail;
  countT [NumFifos-1:0] count;

  // One link read in flight, and the FIFO whose head it will become
  logic rdPending;
  fifoIdT rdFifo;

  // Append onto a one-item list while that item is consumed
  logic coincide;

  assign coincide = appendValid && consumeValid && (appendFifoId == consumeFifoId) &&
                    (count[consumeFifoId] == countT'(1));

  always_comb begin
    for (int f = 0; f < NumFifos; f++) begin
      listEmpty[f] = (count[f] == '0);
      // Head is stale while its replacement is still coming out of the RAM
      headValid[f] = !listEmpty[f] && !(rdPending && (rdFifo == fifoIdT'(f)));
    end
  end

  // Link the old tail to the new entry whenever the list already holds items
  assign ptrWrEn = appendValid && (count[appendFifoId] != '0);
  assign ptrWrAddr = tail[appendFifoId];
  assign ptrWrData = appendEntry;

  // Only follow the link if something stays behind the consumed head
  assign ptrRdEn = consumeValid && (count[consumeFifoId] > countT'(1));
  assign ptrRdAddr = head[consumeFifoId];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      head <= '0;
      tail <= '0;
      count <= '0;
      rdPending <= 1'b0;
      rdFifo <= '0;
    end else begin
      rdPending <= ptrRdEn;
      if (ptrRdEn) begin
        rdFifo <= consumeFifoId;
      end
      // Link data is back, it is the next head
      if (rdPending) begin
        head[rdFifo] <= ptrRdData;
      end
      if (appendValid) begin
        tail[appendFifoId] <= appendEntry;
        // Empty list, or the only item leaves now: new entry is head at once
        if ((count[appendFifoId] == '0) || coincide) begin
          head[appendFifoId] <= appendEntry;
        end
      end
      for (int f = 0; f < NumFifos; f++) begin
        count[f] <= count[f] +
                    countT'(appendValid && (appendFifoId == fifoIdT'(f))) -
                    countT'(consumeValid && (consumeFifoId == fifoIdT'(f)));
      end
    end
  end

  // Pop side may only consume a head that is present and settled
  consumeLegal: assert property (@(posedge clk) disable iff (!rstN)
    consumeValid |-> headValid[consumeFifoId]);

endmodule

`default_nettype wire

// ==== hdl/pushCtrl.sv ====
/*
  Push controller
  Keeps the free-entry bitmap, allocates the lowest free entry for each
  push, writes the data RAM and tells the pointer manager to append
*/
`timescale 1ns/1ps
`default_nettype none

module pushCtrl
  import mfifoPkg::*;
(
  input  logic   clk,
  input  logic   rstN,
  input  logic   pushValid,
  input  fifoIdT pushFifoId,
  input  dataT   pushData,
  input  logic   freeValid,
  input  addrT   freeEntry,
  output logic   pushFull,
  output logic   dataWrEn,
  output addrT   dataWrAddr,
  output dataT   dataWrData,
  output logic   appendValid,
  output fifoIdT appendFifoId,
  output addrT   appendEntry
);

  // One bit per RAM entry, set while the entry is unused
  logic [Depth-1:0] freeMap;
  addrT allocEntry;

  // Priority encoder, the lowest free entry wins
  always_comb begin
    allocEntry = '0;
    for (int i = Depth - 1; i >= 0; i--) begin
      if (freeMap[i]) begin
        allocEntry = addrT'(i);
      end
    end
  end

  assign pushFull = ~|freeMap;

  // Allocation is combinational so the RAM write lands in the push cycle
  assign dataWrEn = pushValid;
  assign dataWrAddr = allocEntry;
  assign dataWrData = pushData;

  // Same entry is handed to the pointer manager as the new tail
  assign appendValid = pushValid;
  assign appendFifoId = pushFifoId;
  assign appendEntry = allocEntry;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      freeMap <= '1;
    end else begin
      if (pushValid) begin
        freeMap[allocEntry] <= 1'b0;
      end
      // A freed entry is never the one being allocated, it was in use
      if (freeValid) begin
        freeMap[freeEntry] <= 1'b1;
      end
    end
  end

  // The credit loop must keep the sender away from a full RAM
  noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
    pushValid |-> !pushFull);

  // The pop side must only return entries that hold data
  noDoubleFree: assert property (@(posedge clk) disable iff (!rstN)
    freeValid |-> !freeMap[freeEntry]);

endmodule

`default_nettype wire

// ==== hdl/sharedFifoTop.sv ====
/*
  Shared-storage multi-FIFO top level
  Credit push port, four valid/ready pop ports, data and pointer RAMs
*/
`timescale 1ns/1ps
`default_nettype none

module sharedFifoTop
  import mfifoPkg::*;
(
  input  logic                clk,
  input  logic                rstN,
  input  logic                pushValid,
  input  fifoIdT              pushFifoId,
  input  dataT                pushData,
  output logic                pushCredit,
  output logic                pushFull,
  output logic [NumFifos-1:0] popValid,
  input  logic [NumFifos-1:0] popReady,
  output dataT [NumFifos-1:0] popData,
  output logic [NumFifos-1:0] popEmpty
);

  logic freeValid, appendValid, consumeValid;
  addrT freeEntry, appendEntry;
  fifoIdT appendFifoId, consumeFifoId;
  logic dataWrEn, dataRdEn, ptrWrEn, ptrRdEn;
  addrT dataWrAddr, dataRdAddr, ptrWrAddr, ptrWrData, ptrRdAddr, ptrRdData;
  dataT dataWrData, dataRdData;
  logic [NumFifos-1:0] listEmpty, headValid;
  addrT [NumFifos-1:0] head;

  creditCounter creditCounter0 (.clk, .rstN, .freeValid, .pushCredit);

  pushCtrl pushCtrl0 (.clk, .rstN, .pushValid, .pushFifoId, .pushData, .freeValid,
    .freeEntry, .pushFull, .dataWrEn, .dataWrAddr, .dataWrData, .appendValid,
    .appendFifoId, .appendEntry);

  ptrMgr ptrMgr0 (.clk, .rstN, .appendValid, .appendFifoId, .appendEntry, .consumeValid,
    .consumeFifoId, .ptrRdData, .listEmpty, .headValid, .head, .ptrWrEn, .ptrWrAddr,
    .ptrWrData, .ptrRdEn, .ptrRdAddr);

  popCtrl popCtrl0 (.clk, .rstN, .listEmpty, .headValid, .head, .dataRdData, .popReady,
    .consumeValid, .consumeFifoId, .freeValid, .freeEntry, .dataRdEn, .dataRdAddr,
    .popValid, .popData, .popEmpty);

  // Payload storage
  syncRam #(.DataWidth(Width)) dataRam0 (.clk, .wrEn(dataWrEn), .wrAddr(dataWrAddr),
    .wrData(dataWrData), .rdEn(dataRdEn), .rdAddr(dataRdAddr), .rdData(dataRdData));

  // Next-entry links of all lists
  syncRam #(.DataWidth(AddrWidth)) ptrRam0 (.clk, .wrEn(ptrWrEn), .wrAddr(ptrWrAddr),
    .wrData(ptrWrData), .rdEn(ptrRdEn), .rdAddr(ptrRdAddr), .rdData(ptrRdData));

endmodule

`default_nettype wire

// ==== hdl/syncRam.sv ====
/*
  Synchronous RAM, one write port and one read port
  Read data appears one cycle after the read request
*/
`timescale 1ns/1ps
`default_nettype none

module syncRam
  import mfifoPkg::*;
#(
  parameter int DataWidth = Width
) (
  input  logic                 clk,
  input  logic                 wrEn,
  input  addrT                 wrAddr,
  input  logic [DataWidth-1:0] wrData,
  input  logic                 rdEn,
  input  addrT                 rdAddr,
  output logic [DataWidth-1:0] rdData
);

  logic [DataWidth-1:0] mem [Depth];

  // Read and write share the edge, a colliding read sees the old word
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[wrAddr] <= wrData;
    end
    if (rdEn) begin
      rdData <= mem[rdAddr];
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the shared multi-FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module sharedFifoTb -f sim.f -o simv

./obj_dir/simv | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// ==== sim.f ====
hdl/mfifoPkg.sv
hdl/creditCounter.sv
hdl/pushCtrl.sv
hdl/ptrMgr.sv
hdl/syncRam.sv
hdl/popCtrl.sv
hdl/sharedFifoTop.sv
verif/sharedFifoTb.sv

// ==== verif/sharedFifoTb.sv ====
/*
  Testbench for the shared-storage multi-FIFO
  Random pushes and pop back-pressure from a fixed seed, checked against
  per-FIFO queue models and a model of the sender's credits
*/
`timescale 1ns/1ps
`default_nettype none

module sharedFifoTb
  import mfifoPkg::*;
();

  logic clk;
  logic rstN;
  logic pushValid;
  fifoIdT pushFifoId;
  dataT pushData;
  logic pushCredit;
  logic pushFull;
  logic [NumFifos-1:0] popValid;
  logic [NumFifos-1:0] popReady;
  dataT [NumFifos-1:0] popData;
  logic [NumFifos-1:0] popEmpty;

  integer seed;
  int credits;
  int pushCount;
  int waitCycles;
  // Expected contents of every logical FIFO, oldest word first
  dataT modelQ [NumFifos][$];
  // FIFOs that showed valid data without ready in the previous cycle
  logic [NumFifos-1:0] stalled;
  dataT heldData [NumFifos];
  int phasePops [NumFifos];
  logic [NumFifos-1:0] ready;

  sharedFifoTop dut0 (.clk, .rstN, .pushValid, .pushFifoId, .pushData, .pushCredit,
    .pushFull, .popValid, .popReady, .popData, .popEmpty);

  always #10 clk = ~clk;

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic compareData(input string name, input dataT expected, input dataT actual);
    if (actual !== expected) begin
      failRun($sformatf("error %0t %s expected %h actual %h", $time, name, expected, actual));
    end
  endtask

  task automatic compareCount(input string name, input countT expected, input countT actual);
    if (actual !== expected) begin
      failRun($sformatf("error %0t %s expected %0d actual %0d", $time, name, expected, actual));
    end
  endtask

  task automatic compareFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      failRun($sformatf("error %0t %s expected %b actual %b", $time, name, expected, actual));
    end
  endtask

  // Called right after a rising edge, so every DUT output still shows
  // the value it had during the cycle that just ended
  task automatic checkOutputs();
    int held;
    if (pushCredit) begin
      credits++;
    end
    compareFlag("creditsInRange", 1'b1, credits >= 0 && credits <= Depth);
    // Every credit held stands for a free entry
    if (credits > 0) begin
      compareFlag("pushFull", 1'b0, pushFull);
    end
    for (int i = 0; i < NumFifos; i++) begin
      // A word pushed in the cycle that just ended is not in the list yet
      held = modelQ[i].size();
      if (pushValid && pushFifoId == fifoIdT'(i)) begin
        held--;
      end
      compareFlag($sformatf("popEmpty[%0d]", i), held == 0, popEmpty[i]);
      if (stalled[i]) begin
        compareFlag($sformatf("popValid[%0d]", i), 1'b1, popValid[i]);
        compareData($sformatf("popData[%0d]", i), heldData[i], popData[i]);
      end
      if (popValid[i]) begin
        if (modelQ[i].size() == 0) begin
          failRun($sformatf("FIFO %0d offered data that was never pushed", i));
        end
        compareData($sformatf("popData[%0d]", i), modelQ[i][0], popData[i]);
        if (popReady[i]) begin
          void'(modelQ[i].pop_front());
          phasePops[i]++;
        end
      end
      stalled[i] = popValid[i] && !popReady[i];
      heldData[i] = popData[i];
    end
  endtask

  // A negative bias means the FIFO ID is fully random
  task automatic driveInputs(input logic allowPush, input int bias,
                             input logic [NumFifos-1:0] readyNext);
    logic [31:0] r;
    fifoIdT id;
    dataT d;
    r = $random(seed);
    popReady <= readyNext;
    if (allowPush && credits > 0 && r[0]) begin
      if (bias >= 0 && r[2:1] != 2'b00) begin
        id = fifoIdT'(bias);
      end else begin
        id = r[4:3];
      end
      d = r[12:5];
      credits--;
      modelQ[id].push_back(d);
      pushCount++;
      pushValid <= 1'b1;
      pushFifoId <= id;
      pushData <= d;
    end else begin
      pushValid <= 1'b0;
    end
  endtask

  task automatic stepCycle(input logic allowPush, input int bias,
                           input logic [NumFifos-1:0] readyNext);
    @(posedge clk);
    checkOutputs();
    driveInputs(allowPush, bias, readyNext);
  endtask

  // Each ready bit is high three times out of four
  function automatic logic [NumFifos-1:0] randomReady();
    logic [31:0] r;
    r = $random(seed);
    return r[3:0] | r[7:4];
  endfunction

  function automatic logic queuesEmpty();
    logic empty;
    empty = 1'b1;
    for (int i = 0; i < NumFifos; i++) begin
      if (modelQ[i].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  initial begin
    seed = 94421;
    clk = 1'b0;
    rstN = 1'b0;
    pushValid = 1'b0;
    pushFifoId = '0;
    pushData = '0;
    popReady = '0;
    credits = 0;
    pushCount = 0;
    stalled = '0;
    for (int i = 0; i < NumFifos; i++) begin
      heldData[i] = '0;
      phasePops[i] = 0;
    end
    repeat (3) @(posedge clk);
    rstN <= 1'b1;

    // Initial credit release, nothing may show up on the pop side yet
    waitCycles = 0;
    while (credits < Depth) begin
      if (waitCycles == 40) begin
        failRun("the initial credits were not all released after reset");
      end
      stepCycle(1'b0, -1, '0);
      compareFlag("anyPopValid", 1'b0, |popValid);
      compareFlag("allPopEmpty", 1'b1, &popEmpty);
      waitCycles++;
    end
    repeat (5) stepCycle(1'b0, -1, '0);
    compareCount("credits", countT'(Depth), countT'(credits));

    // Fully random traffic
    for (int c = 0; c < 600; c++) begin
      stepCycle(1'b1, -1, randomReady());
    end

    // Pushes lean toward FIFO 0 while FIFO 2 is held back for long stretches
    for (int i = 0; i < NumFifos; i++) begin
      phasePops[i] = 0;
    end
    for (int c = 0; c < 600; c++) begin
      ready = randomReady();
      ready[2] = (c % 150) >= 130;
      stepCycle(1'b1, 0, ready);
    end
    for (int i = 0; i < NumFifos; i++) begin
      if (i != 2) begin
        compareFlag($sformatf("drainedDuringStall[%0d]", i), 1'b1, phasePops[i] > 0);
      end
    end

    // Drain everything and wait for all credits to come back
    waitCycles = 0;
    while (!queuesEmpty() || credits != Depth) begin
      if (waitCycles == 400) begin
        failRun("the FIFOs did not drain or the credits did not all return");
      end
      stepCycle(1'b0, -1, '1);
      waitCycles++;
    end
    repeat (10) begin
      stepCycle(1'b0, -1, '1);
      compareFlag("anyPopValid", 1'b0, |popValid);
    end
    compareCount("credits", countT'(Depth), countT'(credits));
    compareFlag("pushFull", 1'b0, pushFull);
    compareFlag("allPopEmpty", 1'b1, &popEmpty);

    if (pushCount > 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      failRun("no word was pushed during the run");
    end
  end

endmodule

`default_nettype wire
